// ==== logic/ipod_pkg.sv ====
package ipod_pkg;

  // ==========================================================================
  // Flash and sample widths
  // ==========================================================================

  localparam int unsigned FLASH_ADDR_W = 22;
  localparam int unsigned FLASH_DATA_W = 32;
  localparam int unsigned SAMPLE_W     = 16;

  // Upper bits are the flash word address, bit 0 picks the half word
  typedef logic [FLASH_ADDR_W:0] sample_idx_t;

  // Wrap point for both playback directions
  localparam sample_idx_t SAMPLE_LAST = '1;

  // Playback direction encoding
  localparam logic DIR_FWD = 1'b0;
  localparam logic DIR_BWD = 1'b1;

  // ==========================================================================
  // Sample period, in CLK_50M cycles
  // ==========================================================================

  localparam int unsigned PERIOD_W = 16;

  localparam logic [PERIOD_W-1:0] PERIOD_DEFAULT = 16'd22000;
  localparam logic [PERIOD_W-1:0] PERIOD_STEP    = 16'd2000;
  localparam logic [PERIOD_W-1:0] PERIOD_MIN     = 16'd2000;
  localparam logic [PERIOD_W-1:0] PERIOD_MAX     = 16'd42000;

  // ==========================================================================
  // Keyboard commands, upper case ASCII
  // ==========================================================================

  localparam logic [7:0] CMD_PLAY     = 8'h45;
  localparam logic [7:0] CMD_PAUSE    = 8'h44;
  localparam logic [7:0] CMD_FORWARD  = 8'h46;
  localparam logic [7:0] CMD_BACKWARD = 8'h42;
  localparam logic [7:0] CMD_RESTART  = 8'h52;

  // Lower case range, folded by clearing bit 5
  localparam logic [7:0] ASCII_LOWER_A = 8'h61;
  localparam logic [7:0] ASCII_LOWER_Z = 8'h7A;
  localparam logic [7:0] ASCII_FOLD    = 8'hDF;

endpackage

// ==== logic/speed_ctrl.sv ====
`timescale 1ns/1ps

module speed_ctrl (
  input  logic                         CLK_50M,
  input  logic                         arst_n,
  input  logic                         speed_up,
  input  logic                         speed_down,
  input  logic                         speed_reset,
  output logic [ipod_pkg::PERIOD_W-1:0] period
);

  import ipod_pkg::*;

  // Bit 0 up, bit 1 down, bit 2 reset
  logic [2:0] sync_meta;
  logic [2:0] sync_lvl;
  logic [2:0] sync_prev;
  logic [2:0] press;

  // Two-flop synchronizer plus one flop for edge detection
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sync_meta <= '0;
      sync_lvl  <= '0;
      sync_prev <= '0;
    end
    else
    begin
      sync_meta <= {speed_reset, speed_down, speed_up};
      sync_lvl  <= sync_meta;
      sync_prev <= sync_lvl;
    end
  end

  assign press = sync_lvl & ~sync_prev;

  // Saturating period register, reset beats up beats down
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      period <= PERIOD_DEFAULT;
    end
    else if (press[2])
    begin
      period <= PERIOD_DEFAULT;
    end
    else if (press[0])
    begin
      if (period >= PERIOD_MIN + PERIOD_STEP)
        period <= period - PERIOD_STEP;
      else
        period <= PERIOD_MIN;
    end
    else if (press[1])
    begin
      if (period <= PERIOD_MAX - PERIOD_STEP)
        period <= period + PERIOD_STEP;
      else
        period <= PERIOD_MAX;
    end
  end

endmodule

// ==== logic/sample_tick_gen.sv ====
`timescale 1ns/1ps

module sample_tick_gen (
  input  logic                         CLK_50M,
  input  logic                         arst_n,
  input  logic [ipod_pkg::PERIOD_W-1:0] period,
  output logic                         tick
);

  import ipod_pkg::*;

  logic [PERIOD_W-1:0] cnt;

  // Down counter, reloads from the period in force at the wrap
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cnt <= PERIOD_DEFAULT - 1'b1;
    end
    else if (cnt == '0)
    begin
      cnt <= period - 1'b1;
    end
    else
    begin
      cnt <= cnt - 1'b1;
    end
  end

  // One cycle in every period
  assign tick = (cnt == '0);

endmodule

// ==== logic/kbd_cmd_fsm.sv ====
`timescale 1ns/1ps

module kbd_cmd_fsm (
  input  logic       CLK_50M,
  input  logic       arst_n,
  input  logic [7:0] kbd_ascii,
  input  logic       kbd_valid,
  output logic       play,
  output logic       dir,
  output logic       restart
);

  import ipod_pkg::*;

  logic [7:0] code;

  // Fold lower case letters onto upper case
  always_comb
  begin
    if (kbd_ascii >= ASCII_LOWER_A && kbd_ascii <= ASCII_LOWER_Z)
      code = kbd_ascii & ASCII_FOLD;
    else
      code = kbd_ascii;
  end

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      play    <= 1'b0;
      dir     <= DIR_FWD;
      restart <= 1'b0;
    end
    else
    begin
      // Restart only lasts one cycle
      restart <= 1'b0;
      if (kbd_valid)
      begin
        case (code)
          CMD_PLAY:     play    <= 1'b1;
          CMD_PAUSE:    play    <= 1'b0;
          CMD_FORWARD:  dir     <= DIR_FWD;
          CMD_BACKWARD: dir     <= DIR_BWD;
          CMD_RESTART:  restart <= 1'b1;
          // Anything else is ignored
          default:      ;
        endcase
      end
    end
  end

endmodule

// ==== logic/addr_ctrl.sv ====
`timescale 1ns/1ps

module addr_ctrl (
  input  logic                  CLK_50M,
  input  logic                  arst_n,
  input  logic                  step,
  input  logic                  restart,
  input  logic                  play,
  input  logic                  dir,
  output ipod_pkg::sample_idx_t idx
);

  import ipod_pkg::*;

  // Sample index walk, restart has priority over a step
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      idx <= '0;
    end
    else if (restart)
    begin
      idx <= '0;
    end
    else if (step && play)
    begin
      if (dir == DIR_FWD)
      begin
        // Forward wrap at the top of flash
        if (idx == SAMPLE_LAST)
          idx <= '0;
        else
          idx <= idx + 1'b1;
      end
      else
      begin
        // Backward wrap at index 0
        if (idx == '0)
          idx <= SAMPLE_LAST;
        else
          idx <= idx - 1'b1;
      end
    end
  end

endmodule

// ==== logic/flash_read_fsm.sv ====
`timescale 1ns/1ps

module flash_read_fsm (
  input  logic                             CLK_50M,
  input  logic                             arst_n,
  input  logic                             tick,
  input  logic                             play,
  input  ipod_pkg::sample_idx_t            idx,
  input  logic                             flash_waitrequest,
  input  logic [ipod_pkg::FLASH_DATA_W-1:0] flash_readdata,
  input  logic                             flash_readdatavalid,
  output logic                             flash_read,
  output logic [ipod_pkg::FLASH_ADDR_W-1:0] flash_addr,
  output logic [ipod_pkg::SAMPLE_W-1:0]     audio_sample,
  output logic                             audio_valid,
  output logic                             step
);

  import ipod_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT
  } state_t;

  state_t      state;
  sample_idx_t idx_q;
  logic        accept_tick;

  // Ticks are dropped unless idle and playing
  assign accept_tick = (state == ST_IDLE) && tick && play;

  // ==========================================================================
  // Read sequencing
  // ==========================================================================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state       <= ST_IDLE;
      audio_valid <= 1'b0;
    end
    else
    begin
      audio_valid <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (accept_tick)
            state <= ST_REQ;
        end
        ST_REQ:
        begin
          if (!flash_waitrequest)
            state <= ST_WAIT;
        end
        ST_WAIT:
        begin
          // Back to idle once the index has stepped
          if (audio_valid)
            state <= ST_IDLE;
          else if (flash_readdatavalid)
            audio_valid <= 1'b1;
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // ==========================================================================
  // Address latch and sample capture
  // ==========================================================================

  always_ff @(posedge CLK_50M)
  begin
    if (accept_tick)
      idx_q <= idx;
    if (state == ST_WAIT && flash_readdatavalid && !audio_valid)
      audio_sample <= idx_q[0] ? flash_readdata[FLASH_DATA_W-1:SAMPLE_W]
                               : flash_readdata[SAMPLE_W-1:0];
  end

  assign flash_read = (state == ST_REQ);
  assign flash_addr = idx_q[FLASH_ADDR_W:1];

  // Index advances together with the output strobe
  assign step = audio_valid;

endmodule

// ==== logic/ipod_top.sv ====
`timescale 1ns/1ps

module ipod_top (
  input  logic                             CLK_50M,
  input  logic                             arst_n,
  input  logic [7:0]                       kbd_ascii,
  input  logic                             kbd_valid,
  input  logic                             speed_up,
  input  logic                             speed_down,
  input  logic                             speed_reset,
  input  logic                             flash_waitrequest,
  input  logic [ipod_pkg::FLASH_DATA_W-1:0] flash_readdata,
  input  logic                             flash_readdatavalid,
  output logic                             flash_read,
  output logic [ipod_pkg::FLASH_ADDR_W-1:0] flash_addr,
  output logic [ipod_pkg::SAMPLE_W-1:0]     audio_sample,
  output logic                             audio_valid
);

  import ipod_pkg::*;

  logic [PERIOD_W-1:0] period;
  logic                tick;
  logic                play;
  logic                dir;
  logic                restart;
  logic                step;
  sample_idx_t         idx;

  // ==========================================================================
  // Sample pacing
  // ==========================================================================

  speed_ctrl speed_ctrl_inst (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .period      (period)
  );

  sample_tick_gen sample_tick_gen_inst (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .period  (period),
    .tick    (tick)
  );

  // ==========================================================================
  // Controls and flash access
  // ==========================================================================

  kbd_cmd_fsm kbd_cmd_fsm_inst (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .kbd_ascii (kbd_ascii),
    .kbd_valid (kbd_valid),
    .play      (play),
    .dir       (dir),
    .restart   (restart)
  );

  addr_ctrl addr_ctrl_inst (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .step    (step),
    .restart (restart),
    .play    (play),
    .dir     (dir),
    .idx     (idx)
  );

  flash_read_fsm flash_read_fsm_inst (
    .CLK_50M             (CLK_50M),
    .arst_n              (arst_n),
    .tick                (tick),
    .play                (play),
    .idx                 (idx),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_read          (flash_read),
    .flash_addr          (flash_addr),
    .audio_sample        (audio_sample),
    .audio_valid         (audio_valid),
    .step                (step)
  );

endmodule

// ==== dv/ipod_sva.sv ====
`timescale 1ns/1ps

module ipod_sva (
  input logic                             CLK_50M,
  input logic                             arst_n,
  input logic                             play,
  input logic                             flash_read,
  input logic                             flash_waitrequest,
  input logic [ipod_pkg::FLASH_ADDR_W-1:0] flash_addr,
  input logic                             audio_valid
);

  // Request and address held until the flash takes them
  assert property (@(posedge CLK_50M) disable iff (!arst_n)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_addr))
    else $error("flash request changed before it was accepted");

  // Output strobe lasts a single cycle
  assert property (@(posedge CLK_50M) disable iff (!arst_n)
    audio_valid |=> !audio_valid)
    else $error("audio_valid stayed high for more than one cycle");

  // Reads start only from a tick taken while playing
  assert property (@(posedge CLK_50M) disable iff (!arst_n)
    $rose(flash_read) |-> $past(play))
    else $error("flash read started while paused");

endmodule

// ==== dv/tb_ipod.sv ====
`timescale 1ns/1ps

module tb_ipod;

  import ipod_pkg::*;

  // Upper bound on samples the sequence waits for
  localparam int unsigned PLANNED_SAMPLES = 64;

  logic                    CLK_50M;
  logic                    arst_n;
  logic [7:0]              kbd_ascii;
  logic                    kbd_valid;
  logic                    speed_up;
  logic                    speed_down;
  logic                    speed_reset;
  logic                    flash_waitrequest;
  logic [FLASH_DATA_W-1:0] flash_readdata;
  logic                    flash_readdatavalid;
  logic                    flash_read;
  logic [FLASH_ADDR_W-1:0] flash_addr;
  logic [SAMPLE_W-1:0]     audio_sample;
  logic                    audio_valid;

  string       test_name = "reset";
  sample_idx_t exp_idx = '0;
  logic        model_play = 1'b0;
  logic        model_dir = 1'b0;
  int unsigned model_period = PERIOD_DEFAULT;
  int unsigned cycle_cnt = 0;
  int unsigned last_rise = 0;
  int unsigned last_spacing = 0;
  int unsigned rise_count = 0;
  int unsigned sample_count = 0;
  int unsigned check_count = 0;
  int unsigned error_count = 0;
  logic        read_q = 1'b0;

  ipod_top ipod_top_inst (.*);

  bind flash_read_fsm ipod_sva ipod_sva_inst (.*);

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ==========================================================================
  // Reference model and checking
  // ==========================================================================

  // Low half is the word address, high half has A5A5 mixed in
  function automatic logic [SAMPLE_W-1:0] expected_sample(input sample_idx_t idx);
    logic [15:0] addr_lo;
    addr_lo = idx[16:1];
    return idx[0] ? (addr_lo ^ 16'hA5A5) : addr_lo;
  endfunction

  function automatic sample_idx_t next_idx(input sample_idx_t idx, input logic bwd);
    if (bwd)
      return (idx == '0) ? '1 : idx - 1'b1;
    return (idx == '1) ? '0 : idx + 1'b1;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual)
    begin
      error_count++;
      $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
    end
  endtask

  // Read spacing monitor and sample compare
  always @(posedge CLK_50M)
  begin
    cycle_cnt++;
    if (flash_read && !read_q)
    begin
      last_spacing = cycle_cnt - last_rise;
      last_rise    = cycle_cnt;
      rise_count++;
    end
    read_q = flash_read;
    if (audio_valid === 1'b1)
    begin
      check_value(test_name, expected_sample(exp_idx), audio_sample);
      sample_count++;
      if (model_play)
        exp_idx = next_idx(exp_idx, model_dir);
    end
  end

  // Flash with random wait states and read latency
  initial
  begin : flash_model
    int unsigned             wait_cycles;
    int unsigned             latency;
    logic [FLASH_ADDR_W-1:0] addr;
    void'($urandom(32'h1b29));
    forever
    begin
      @(posedge CLK_50M);
      if (flash_read === 1'b1)
      begin
        // Waitrequest idles high so a read sees at least one wait cycle
        wait_cycles = $urandom_range(3, 0);
        repeat (wait_cycles) @(posedge CLK_50M);
        flash_waitrequest <= 1'b0;
        @(posedge CLK_50M);
        flash_waitrequest <= 1'b1;
        addr    = flash_addr;
        // Full word address of the sample in flight
        check_value({test_name, "_addr"}, exp_idx[FLASH_ADDR_W:1], addr);
        latency = $urandom_range(8, 1);
        repeat (latency - 1) @(posedge CLK_50M);
        flash_readdata      <= {addr[15:0] ^ 16'hA5A5, addr[15:0]};
        flash_readdatavalid <= 1'b1;
        @(posedge CLK_50M);
        flash_readdatavalid <= 1'b0;
      end
    end
  end

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  task automatic send_cmd(input logic [7:0] code);
    logic [7:0] upper;
    upper = (code >= "a" && code <= "z") ? code - 8'h20 : code;
    @(posedge CLK_50M);
    kbd_ascii <= code;
    kbd_valid <= 1'b1;
    @(posedge CLK_50M);
    kbd_valid <= 1'b0;
    case (upper)
      "E":     model_play = 1'b1;
      "D":     model_play = 1'b0;
      "F":     model_dir = 1'b0;
      "B":     model_dir = 1'b1;
      "R":     exp_idx = '0;
      default: ;
    endcase
  endtask

  task automatic wait_samples(input int unsigned n);
    int unsigned target;
    target = sample_count + n;
    while (sample_count < target)
      @(posedge CLK_50M);
    @(posedge CLK_50M);
  endtask

  // Keys are {reset, down, up}
  task automatic press_speed(input logic [2:0] keys, input int unsigned times);
    repeat (times)
    begin
      @(posedge CLK_50M);
      {speed_reset, speed_down, speed_up} <= keys;
      repeat (4) @(posedge CLK_50M);
      {speed_reset, speed_down, speed_up} <= 3'b000;
      repeat (4) @(posedge CLK_50M);
      if (keys[2])
        model_period = PERIOD_DEFAULT;
      else if (keys[0])
        model_period = (model_period > PERIOD_MIN + PERIOD_STEP) ?
                       model_period - PERIOD_STEP : PERIOD_MIN;
      else if (keys[1])
        model_period = (model_period + PERIOD_STEP < PERIOD_MAX) ?
                       model_period + PERIOD_STEP : PERIOD_MAX;
    end
  endtask

  // Presses land after a reload, so the second read interval that follows has the new period
  task automatic speed_check(input logic [2:0] keys, input int unsigned times,
                             input string name);
    int unsigned target;
    wait_samples(1);
    press_speed(keys, times);
    target = rise_count + 2;
    while (rise_count < target)
      @(posedge CLK_50M);
    check_value(name, model_period, last_spacing);
  endtask

  task automatic pause_check(input logic [7:0] pause_code, input logic [7:0] play_code);
    int unsigned held;
    send_cmd(pause_code);
    held = sample_count;
    // Long enough for ticks under any period still counting down
    repeat (2 * PERIOD_MAX) @(posedge CLK_50M);
    check_value({test_name, "_paused"}, held, sample_count);
    send_cmd(play_code);
    wait_samples(2);
  endtask

  initial
  begin
    arst_n              <= 1'b0;
    kbd_ascii           <= 8'h00;
    kbd_valid           <= 1'b0;
    speed_up            <= 1'b0;
    speed_down          <= 1'b0;
    speed_reset         <= 1'b0;
    flash_waitrequest   <= 1'b1;
    flash_readdata      <= '0;
    flash_readdatavalid <= 1'b0;
    repeat (10) @(posedge CLK_50M);
    arst_n <= 1'b1;

    test_name = "idle_after_reset";
    repeat (PERIOD_DEFAULT + 100) @(posedge CLK_50M);
    check_value(test_name, 0, rise_count);
    test_name = "forward_play";
    send_cmd("E");
    wait_samples(6);

    test_name = "speed";
    speed_check(3'b000, 0, "period_default");
    speed_check(3'b001, 1, "period_up_one");
    speed_check(3'b001, 10, "period_min");
    speed_check(3'b010, 1, "period_down_one");
    speed_check(3'b010, 20, "period_max");
    speed_check(3'b100, 1, "period_restored");
    // Shortest period for the rest
    wait_samples(1);
    press_speed(3'b001, 10);

    test_name = "pause_resume";
    pause_check("D", "E");
    test_name = "backward_wrap";
    send_cmd("R");
    send_cmd("B");
    wait_samples(3);
    test_name = "forward_wrap";
    send_cmd("F");
    wait_samples(4);

    test_name = "restart_fwd";
    send_cmd("R");
    wait_samples(2);
    test_name = "restart_bwd";
    send_cmd("B");
    wait_samples(2);
    send_cmd("R");
    wait_samples(2);
    test_name = "lower_case";
    send_cmd("f");
    send_cmd("r");
    wait_samples(2);
    pause_check("d", "e");
    send_cmd("b");
    wait_samples(2);
    test_name = "other_codes";
    send_cmd("X");
    send_cmd("q");
    send_cmd(8'hC5);
    wait_samples(3);

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  initial
  begin
    repeat (PLANNED_SAMPLES * PERIOD_MAX * 2 + 10000) @(posedge CLK_50M);
    $display("Watchdog expired before the test sequence finished");
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== tb.f ====
logic/ipod_pkg.sv
logic/speed_ctrl.sv
logic/sample_tick_gen.sv
logic/kbd_cmd_fsm.sv
logic/addr_ctrl.sv
logic/flash_read_fsm.sv
logic/ipod_top.sv
dv/ipod_sva.sv
dv/tb_ipod.sv

// ==== Bender.yml ====
package:
  name: ipod_playback

sources:
  - logic/ipod_pkg.sv
  - logic/speed_ctrl.sv
  - logic/sample_tick_gen.sv
  - logic/kbd_cmd_fsm.sv
  - logic/addr_ctrl.sv
  - logic/flash_read_fsm.sv
  - logic/ipod_top.sv
  - target: simulation
    files:
      - dv/ipod_sva.sv
      - dv/tb_ipod.sv
